/* list.f */
+incdir+design
design/csr_pkg.sv
design/csr_access_if.sv
design/trap_if.sv
design/csr_cmd_frontend.sv
design/csr_regfile.sv
design/trap_ctrl.sv
design/csr_unit_top.sv
testbench/csr_unit_sva.sv
testbench/tb_csr_unit.sv

/* testbench/tb_csr_unit.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module tb_csr_unit
    import csr_pkg::*;
();

    // Six tests, up to 20 commands of about 10 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 6 * 20 * 10 + 800;

    logic       clk;
    logic       rst_n;
    logic       cmd_req;
    csr_op_t    cmd_op;
    csr_addr_t  cmd_addr;
    xlen_t      cmd_wdata;
    xlen_t      cmd_pc;
    logic       cmd_ack;
    xlen_t      cmd_rdata;
    logic       cmd_err;
    dword_t     mtime;
    dword_t     mtimecmp;
    xlen_t      fetch_pc;
    logic       intr_ready;
    logic       trap_valid;
    xlen_t      trap_vector;
    priv_mode_t priv_mode;
    logic       stall_may_interrupt;

    int    seed;
    int    checks;
    int    errors;
    int    cycles;
    int    trap_count;
    xlen_t trap_vec_seen;
    xlen_t last_rdata;
    logic  last_err;
    int    last_edges;

    csr_unit_top DUT (.*);

    bind csr_unit_top csr_unit_sva u_sva (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .fe_idle    (fe_idle),
        .irq_take   (irq_take),
        .trap_valid (trap_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Trap pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && trap_valid) begin
            trap_count = trap_count + 1;
            trap_vec_seen = trap_vector;
        end
    end

    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s finished with %0d error(s)", name, errors - errors_before);
    endtask

    // One full four-phase command
    task automatic run_cmd(input csr_op_t op, input csr_addr_t addr, input xlen_t wdata);
        last_edges = 0;
        @(negedge clk);
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_req   = 1'b1;
        do begin
            @(negedge clk);
            last_edges++;
        end while (!cmd_ack);
        last_rdata = cmd_rdata;
        last_err   = cmd_err;
        cmd_req    = 1'b0;
        while (cmd_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        run_cmd(OP_SET, `ADDR_MISA, '0);
        check_value("reset misa", `MISA_VALUE, last_rdata);
        check_value("reset misa err", 32'd0, {31'd0, last_err});
        run_cmd(OP_SET, `ADDR_MHARTID, '0);
        check_value("reset mhartid", 32'd0, last_rdata);
        run_cmd(OP_SET, `ADDR_MEPC, '0);
        check_value("reset mepc", 32'd0, last_rdata);
        run_cmd(OP_SET, `ADDR_MCAUSE, '0);
        check_value("reset mcause", 32'd0, last_rdata);
        check_value("reset mode", {30'd0, PRIV_M}, {30'd0, priv_mode});
        report_test("test_reset_values", e0);
    endtask

    task automatic test_mscratch_rmw();
        int    e0;
        xlen_t a;
        xlen_t b;
        xlen_t c;
        e0 = errors;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        // Accept edge plus three, counted from the drive
        run_cmd(OP_WRITE, `ADDR_MSCRATCH, a);
        check_value("rmw write old", 32'd0, last_rdata);
        check_value("rmw write ack edges", 32'd4, last_edges);
        run_cmd(OP_SET, `ADDR_MSCRATCH, b);
        check_value("rmw set old", a, last_rdata);
        check_value("rmw set ack edges", 32'd4, last_edges);
        run_cmd(OP_CLEAR, `ADDR_MSCRATCH, c);
        check_value("rmw clear old", a | b, last_rdata);
        check_value("rmw clear ack edges", 32'd4, last_edges);
        run_cmd(OP_SET, `ADDR_MSCRATCH, '0);
        check_value("rmw final", (a | b) & ~c, last_rdata);
        check_value("rmw err", 32'd0, {31'd0, last_err});
        report_test("test_mscratch_rmw", e0);
    endtask

    task automatic test_misa_refused();
        int e0;
        e0 = errors;
        run_cmd(OP_WRITE, `ADDR_MISA, 32'hffff_ffff);
        check_value("misa write err", 32'd1, {31'd0, last_err});
        check_value("misa write rdata", 32'd0, last_rdata);
        run_cmd(OP_SET, `ADDR_MISA, '0);
        check_value("misa unchanged", `MISA_VALUE, last_rdata);
        run_cmd(OP_SET, 12'h3ff, '0);
        check_value("unimplemented read", 32'd0, last_rdata);
        check_value("unimplemented err", 32'd0, {31'd0, last_err});
        report_test("test_misa_refused", e0);
    endtask

    task automatic test_mret_to_user();
        int    e0;
        int    traps;
        xlen_t first;
        e0 = errors;
        run_cmd(OP_WRITE, `ADDR_MTVEC, 32'h0000_0100);
        run_cmd(OP_WRITE, `ADDR_MEPC, 32'h0000_2000);
        // MPP = user, MIE and MPIE off
        run_cmd(OP_WRITE, `ADDR_MSTATUS, 32'd0);
        traps = trap_count;
        run_cmd(OP_MRET, '0, '0);
        check_true(trap_count == traps + 1, "MRET did not pulse trap_valid once");
        check_value("mret vector", 32'h0000_2000, trap_vec_seen);
        check_value("mret mode", {30'd0, PRIV_U}, {30'd0, priv_mode});
        run_cmd(OP_SET, `ADDR_MSCRATCH, '0);
        check_value("user mscratch err", 32'd1, {31'd0, last_err});
        check_value("user mscratch rdata", 32'd0, last_rdata);
        run_cmd(OP_SET, `ADDR_CYCLE, '0);
        first = last_rdata;
        run_cmd(OP_SET, `ADDR_CYCLE, '0);
        check_true(last_rdata > first, "cycle did not increase between two reads");
        report_test("test_mret_to_user", e0);
    endtask

    task automatic test_ecall_from_user();
        int e0;
        int traps;
        e0 = errors;
        cmd_pc = 32'h0000_3a48;
        traps = trap_count;
        run_cmd(OP_ECALL, '0, '0);
        check_true(trap_count == traps + 1, "ECALL did not pulse trap_valid once");
        check_value("ecall vector", 32'h0000_0100, trap_vec_seen);
        check_value("ecall mode", {30'd0, PRIV_M}, {30'd0, priv_mode});
        run_cmd(OP_SET, `ADDR_MCAUSE, '0);
        check_value("ecall mcause", `CAUSE_ECALL_BASE, last_rdata);
        run_cmd(OP_SET, `ADDR_MEPC, '0);
        check_value("ecall mepc", 32'h0000_3a48, last_rdata);
        run_cmd(OP_SET, `ADDR_MSTATUS, '0);
        check_value("ecall mpp", 32'd0, {30'd0, last_rdata[12:11]});
        check_value("ecall mie", 32'd0, {31'd0, last_rdata[3]});
        report_test("test_ecall_from_user", e0);
    endtask

    task automatic test_timer_interrupt();
        int e0;
        int traps;
        int n;
        e0 = errors;
        run_cmd(OP_WRITE, `ADDR_MIE, 32'h0000_0080);
        run_cmd(OP_SET, `ADDR_MSTATUS, 32'h0000_0008);
        @(negedge clk);
        mtime    = 64'd1000;
        mtimecmp = 64'd900;
        @(negedge clk);
        check_value("timer stall high", 32'd1, {31'd0, stall_may_interrupt});
        traps      = trap_count;
        fetch_pc   = 32'h0000_5a5c;
        intr_ready = 1'b1;
        n = 0;
        while (trap_count == traps && n < 20) begin
            @(negedge clk);
            n++;
        end
        intr_ready = 1'b0;
        check_true(trap_count == traps + 1, "timer interrupt did not pulse trap_valid once");
        check_value("timer vector", 32'h0000_0100, trap_vec_seen);
        run_cmd(OP_SET, `ADDR_MCAUSE, '0);
        check_value("timer mcause", `CAUSE_TIMER_INT, last_rdata);
        run_cmd(OP_SET, `ADDR_MEPC, '0);
        check_value("timer mepc", 32'h0000_5a5c, last_rdata);
        // Trap entry cleared MIE, so turn it back on before clearing it
        run_cmd(OP_SET, `ADDR_MSTATUS, 32'h0000_0008);
        @(negedge clk);
        check_value("timer stall rearmed", 32'd1, {31'd0, stall_may_interrupt});
        run_cmd(OP_CLEAR, `ADDR_MSTATUS, 32'h0000_0008);
        @(negedge clk);
        check_value("timer stall low", 32'd0, {31'd0, stall_may_interrupt});
        mtimecmp = '1;
        report_test("test_timer_interrupt", e0);
    endtask

    initial begin
        seed       = 32'h13bc;
        checks     = 0;
        errors     = 0;
        cycles     = 0;
        trap_count = 0;
        rst_n      = 1'b0;
        cmd_req    = 1'b0;
        cmd_op     = OP_NONE;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        cmd_pc     = '0;
        mtime      = '0;
        mtimecmp   = '1;
        fetch_pc   = '0;
        intr_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_mscratch_rmw();
        test_misa_refused();
        test_mret_to_user();
        test_ecall_from_user();
        test_timer_interrupt();

        errors = errors + DUT.u_sva.fail_count;
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* testbench/csr_unit_sva.sv */
`timescale 1ns/1ps

module csr_unit_sva (
    input logic clk,
    input logic rst_n,
    input logic cmd_req,
    input logic cmd_ack,
    input logic fe_idle,
    input logic irq_take,
    input logic trap_valid
);

    int fail_count = 0;

    // No acknowledge without a request behind it
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else begin
            $error("cmd_ack rose without cmd_req");
            fail_count++;
        end

    // Accept edge, then ack on the third edge after it
    ack_three_edges: assert property (@(posedge clk) disable iff (!rst_n)
        (fe_idle && cmd_req && !irq_take) |=> !cmd_ack [*3] ##1 cmd_ack)
        else begin
            $error("cmd_ack did not follow the accept edge by three edges");
            fail_count++;
        end

    // Ack held while req is high, dropped one cycle after req falls
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_ack && cmd_req) |=> cmd_ack)
        else begin
            $error("cmd_ack dropped while cmd_req still high");
            fail_count++;
        end

    ack_falls: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_ack && !cmd_req) |=> !cmd_ack)
        else begin
            $error("cmd_ack stayed high after cmd_req fell");
            fail_count++;
        end

    trap_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        trap_valid |=> !trap_valid)
        else begin
            $error("trap_valid lasted more than one cycle");
            fail_count++;
        end

endmodule

/* design/csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_req,
    input  csr_op_t    cmd_op,
    input  csr_addr_t  cmd_addr,
    input  xlen_t      cmd_wdata,
    input  xlen_t      cmd_pc,
    output logic       cmd_ack,
    output xlen_t      cmd_rdata,
    output logic       cmd_err,
    input  dword_t     mtime,
    input  dword_t     mtimecmp,
    input  xlen_t      fetch_pc,
    input  logic       intr_ready,
    output logic       trap_valid,
    output xlen_t      trap_vector,
    output priv_mode_t priv_mode,
    output logic       stall_may_interrupt
);

    logic    fe_idle;
    logic    sys_req;
    csr_op_t sys_op;
    logic    irq_take;
    logic    mtip;

    csr_access_if acc_if ();
    trap_if       trp_if ();

    csr_cmd_frontend u_frontend (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .irq_take  (irq_take),
        .priv_mode (priv_mode),
        .cmd_ack   (cmd_ack),
        .cmd_rdata (cmd_rdata),
        .cmd_err   (cmd_err),
        .fe_idle   (fe_idle),
        .sys_req   (sys_req),
        .sys_op    (sys_op),
        .acc       (acc_if.frontend)
    );

    csr_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .acc      (acc_if.regfile),
        .tif      (trp_if.regs),
        .mtip     (mtip)
    );

    trap_ctrl u_trap_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .sys_req             (sys_req),
        .sys_op              (sys_op),
        .fe_idle             (fe_idle),
        .cmd_req             (cmd_req),
        .intr_ready          (intr_ready),
        .mtip                (mtip),
        .fetch_pc            (fetch_pc),
        .cmd_pc              (cmd_pc),
        .irq_take            (irq_take),
        .priv_mode           (priv_mode),
        .trap_valid          (trap_valid),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt),
        .tif                 (trp_if.ctrl)
    );

endmodule

/* design/trap_ctrl.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module trap_ctrl
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sys_req,
    input  csr_op_t    sys_op,
    input  logic       fe_idle,
    input  logic       cmd_req,
    input  logic       intr_ready,
    input  logic       mtip,
    input  xlen_t      fetch_pc,
    input  xlen_t      cmd_pc,
    output logic       irq_take,
    output priv_mode_t priv_mode,
    output logic       trap_valid,
    output xlen_t      trap_vector,
    output logic       stall_may_interrupt,
    trap_if.ctrl       tif
);

    priv_mode_t mode_q;
    logic       irq_pending;
    logic       ecall_take;
    logic       mret_take;

    // MIE only masks the interrupt in machine mode
    assign irq_pending = mtip && tif.mie_mtie && ((mode_q == PRIV_U) || tif.mstatus_mie);
    assign stall_may_interrupt = irq_pending;

    // Only between commands, so the trap never races a CSR write
    assign irq_take   = irq_pending && intr_ready && fe_idle && !cmd_req;
    assign ecall_take = sys_req && (sys_op == OP_ECALL);
    assign mret_take  = sys_req && (sys_op == OP_MRET);

    assign tif.trap_enter  = irq_take || ecall_take;
    assign tif.trap_return = mret_take;
    assign tif.prev_mode   = mode_q;
    assign tif.trap_epc    = irq_take ? fetch_pc : cmd_pc;

    // ECALL cause is 8 from U and 11 from M
    assign tif.trap_cause = irq_take ? `CAUSE_TIMER_INT :
                            `CAUSE_ECALL_BASE + {{(`CSR_XLEN-2){1'b0}}, mode_q};

    assign priv_mode = mode_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q      <= PRIV_M;
            trap_valid  <= 1'b0;
            trap_vector <= '0;
        end else begin
            trap_valid <= tif.trap_enter || tif.trap_return;
            if (tif.trap_enter) begin
                mode_q      <= PRIV_M;
                trap_vector <= tif.mtvec;
            end else if (tif.trap_return) begin
                // Back to the mode saved at trap entry
                mode_q      <= priv_mode_t'(tif.mstatus_mpp);
                trap_vector <= tif.mepc;
            end
        end
    end

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  dword_t         mtime,
    input  dword_t         mtimecmp,
    csr_access_if.regfile  acc,
    trap_if.regs           tif,
    output logic           mtip
);

    // mstatus fields
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_t mstatus_mpp;

    logic       mie_mtie;
    xlen_t      mtvec;
    xlen_t      mscratch;
    xlen_t      mepc;
    xlen_t      mcause;
    dword_t     cycle_cnt;
    xlen_t      rd_val;

    // Timer interrupt pending
    assign mtip = (mtime >= mtimecmp);

    assign tif.mtvec        = mtvec;
    assign tif.mepc         = mepc;
    assign tif.mstatus_mie  = mstatus_mie;
    assign tif.mstatus_mpie = mstatus_mpie;
    assign tif.mstatus_mpp  = mstatus_mpp;
    assign tif.mie_mtie     = mie_mtie;

    // Free-running cycle counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    // Read mux
    always_comb begin
        case (acc.rd_addr)
            `ADDR_MSTATUS: rd_val = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie,
                                     3'b0, mstatus_mie, 3'b0};
            `ADDR_MISA:     rd_val = `MISA_VALUE;
            `ADDR_MIE:      rd_val = {24'b0, mie_mtie, 7'b0};
            `ADDR_MTVEC:    rd_val = mtvec;
            `ADDR_MSCRATCH: rd_val = mscratch;
            `ADDR_MEPC:     rd_val = mepc;
            `ADDR_MCAUSE:   rd_val = mcause;
            `ADDR_MIP:      rd_val = {24'b0, mtip, 7'b0};
            `ADDR_MHARTID:  rd_val = '0;
            `ADDR_CYCLE,
            `ADDR_MCYCLE:   rd_val = cycle_cnt[31:0];
            `ADDR_CYCLEH,
            `ADDR_MCYCLEH:  rd_val = cycle_cnt[63:32];
            default:        rd_val = '0;
        endcase
    end

    assign acc.rd_data = rd_val;

    // Trap entry and return win over a CSR write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_M;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (tif.trap_enter) begin
            mcause       <= tif.trap_cause;
            mepc         <= tif.trap_epc;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= priv_mode_t'(tif.prev_mode);
        end else if (tif.trap_return) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= PRIV_U;
        end else if (acc.wr_en) begin
            case (acc.wr_addr)
                `ADDR_MSTATUS: begin
                    mstatus_mie  <= acc.wr_data[3];
                    mstatus_mpie <= acc.wr_data[7];
                    // Only M and U are legal, anything else maps to U
                    mstatus_mpp  <= (acc.wr_data[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                end
                `ADDR_MIE:      mie_mtie <= acc.wr_data[7];
                `ADDR_MTVEC:    mtvec    <= acc.wr_data;
                `ADDR_MSCRATCH: mscratch <= acc.wr_data;
                `ADDR_MEPC:     mepc     <= {acc.wr_data[31:2], 2'b00};
                `ADDR_MCAUSE:   mcause   <= acc.wr_data;
                default: begin
                end
            endcase
        end
    end

endmodule

/* design/csr_cmd_frontend.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_cmd_frontend
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_req,
    input  csr_op_t       cmd_op,
    input  csr_addr_t     cmd_addr,
    input  xlen_t         cmd_wdata,
    input  logic          irq_take,
    input  priv_mode_t    priv_mode,
    output logic          cmd_ack,
    output xlen_t         cmd_rdata,
    output logic          cmd_err,
    output logic          fe_idle,
    output logic          sys_req,
    output csr_op_t       sys_op,
    csr_access_if.frontend acc
);

    fe_state_t state;
    csr_op_t   op_q;
    csr_addr_t addr_q;
    xlen_t     wdata_q;
    logic      write_ok_q;
    logic      is_sys;
    logic      wants_write;
    logic      denied;
    xlen_t     new_val;

    // Registers with no writable bits, beyond the 11:10 read-only range
    function automatic logic read_only(input csr_addr_t addr);
        return (addr[11:10] == 2'b11) || (addr == `ADDR_MISA) || (addr == `ADDR_MIP) ||
               (addr == `ADDR_MCYCLE) || (addr == `ADDR_MCYCLEH);
    endfunction

    assign is_sys = (op_q == OP_ECALL) || (op_q == OP_MRET);

    // Set and clear with a zero operand only read
    assign wants_write = (op_q == OP_WRITE) ||
                         (((op_q == OP_SET) || (op_q == OP_CLEAR)) && (wdata_q != '0));

    assign denied = (addr_q[9:8] > priv_mode) || (wants_write && read_only(addr_q));

    always_comb begin
        case (op_q)
            OP_WRITE: new_val = wdata_q;
            OP_SET:   new_val = cmd_rdata | wdata_q;
            OP_CLEAR: new_val = cmd_rdata & ~wdata_q;
            default:  new_val = cmd_rdata;
        endcase
    end

    assign acc.rd_addr = addr_q;
    assign acc.wr_addr = addr_q;
    assign acc.wr_data = new_val;
    assign acc.wr_en   = (state == FE_WRITE) && write_ok_q;

    assign fe_idle = (state == FE_IDLE);
    assign sys_req = (state == FE_READ) && is_sys;
    assign sys_op  = op_q;

    // Command fields, held by the requester anyway
    always_ff @(posedge clk) begin
        if (state == FE_IDLE && cmd_req && !irq_take) begin
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FE_IDLE;
            op_q       <= OP_NONE;
            cmd_ack    <= 1'b0;
            cmd_err    <= 1'b0;
            write_ok_q <= 1'b0;
        end else begin
            case (state)
                FE_IDLE: begin
                    // An interrupt taken this cycle goes first
                    if (cmd_req && !irq_take) begin
                        op_q  <= cmd_op;
                        state <= FE_READ;
                    end
                end
                FE_READ: begin
                    cmd_err    <= !is_sys && denied;
                    write_ok_q <= !is_sys && !denied && wants_write;
                    state      <= FE_WRITE;
                end
                FE_WRITE: begin
                    write_ok_q <= 1'b0;
                    state      <= FE_ACK;
                end
                FE_ACK: begin
                    if (!cmd_ack) begin
                        cmd_ack <= 1'b1;
                    end else if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= FE_IDLE;
                    end
                end
                default: state <= FE_IDLE;
            endcase
        end
    end

    // Old value, zero when refused or for ECALL/MRET
    always_ff @(posedge clk) begin
        if (state == FE_READ) begin
            cmd_rdata <= (is_sys || denied) ? '0 : acc.rd_data;
        end
    end

endmodule

/* design/trap_if.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

interface trap_if;

    // Trap entry and return, one cycle each
    logic                 trap_enter;
    logic                 trap_return;
    logic [`CSR_XLEN-1:0] trap_cause;
    logic [`CSR_XLEN-1:0] trap_epc;
    logic [1:0]           prev_mode;

    // State the controller needs back
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic [1:0]           mstatus_mpp;
    logic                 mie_mtie;

    modport ctrl (
        output trap_enter, trap_return, trap_cause, trap_epc, prev_mode,
        input  mtvec, mepc, mstatus_mie, mstatus_mpie, mstatus_mpp, mie_mtie
    );

    modport regs (
        input  trap_enter, trap_return, trap_cause, trap_epc, prev_mode,
        output mtvec, mepc, mstatus_mie, mstatus_mpie, mstatus_mpp, mie_mtie
    );

endinterface

/* design/csr_access_if.sv */
`timescale 1ns/1ps
`include "csr_defs.svh"

interface csr_access_if;

    // Read port, answered combinationally
    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic [`CSR_XLEN-1:0]   rd_data;

    // Write port, applied on the clock edge
    logic                   wr_en;
    logic [`CSR_ADDR_W-1:0] wr_addr;
    logic [`CSR_XLEN-1:0]   wr_data;

    modport frontend (
        output rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data
    );

    modport regfile (
        input  rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

endinterface

/* design/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

    // Data word of the hart
    typedef logic [`CSR_XLEN-1:0] xlen_t;

    // CSR address as found in the instruction
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Timer and counter values
    typedef logic [63:0] dword_t;

    // Only machine and user mode exist
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_t;

    // Command from the pipeline
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_WRITE = 3'd1,
        OP_SET   = 3'd2,
        OP_CLEAR = 3'd3,
        OP_ECALL = 3'd4,
        OP_MRET  = 3'd5
    } csr_op_t;

    // Command front end FSM
    typedef enum logic [1:0] {
        FE_IDLE  = 2'd0,
        FE_READ  = 2'd1,
        FE_WRITE = 2'd2,
        FE_ACK   = 2'd3
    } fe_state_t;

endpackage

/* design/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// Machine trap setup
`define ADDR_MSTATUS        12'h300
`define ADDR_MISA           12'h301
`define ADDR_MIE            12'h304
`define ADDR_MTVEC          12'h305

// Machine trap handling
`define ADDR_MSCRATCH       12'h340
`define ADDR_MEPC           12'h341
`define ADDR_MCAUSE         12'h342
`define ADDR_MIP            12'h344

// Information and counters
`define ADDR_MHARTID        12'hf14
`define ADDR_CYCLE          12'hc00
`define ADDR_CYCLEH         12'hc80
`define ADDR_MCYCLE         12'hb00
`define ADDR_MCYCLEH        12'hb80

// MXL=1, extensions I, M and U
`define MISA_VALUE          32'h4010_1100

// Trap causes
`define CAUSE_TIMER_INT     32'h8000_0007
`define CAUSE_ECALL_BASE    32'd8

`endif
